//--- source/histogram_pkg.sv
package histogram_pkg;

    ////////////////////////////////////////
    // generator modes
    ////////////////////////////////////////

    // codes 6 and 7 are left out on purpose
    // the generator treats them as hold
    typedef enum logic [2:0] {
        // sample forced to zero
        MODE_RESET    = 3'd0,
        // free running sweep over the full range
        MODE_UNIFORM  = 3'd1,
        // repeat lo
        MODE_CONSTANT = 3'd2,
        // sweep inside [lo, hi]
        MODE_INCL     = 3'd3,
        // sweep outside [lo, hi]
        MODE_EXCL     = 3'd4,
        // toggle between lo and hi
        MODE_ALT      = 3'd5
    } gen_mode_t;

    ////////////////////////////////////////
    // readout selects
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        // one bin counter, picked by rd_addr
        RD_BIN   = 2'd0,
        // smallest collected sample
        RD_MIN   = 2'd1,
        // largest collected sample
        RD_MAX   = 2'd2,
        // number of collected samples
        RD_COUNT = 2'd3
    } rd_sel_t;

endpackage

//--- source/histogram_data_gen.sv
module histogram_data_gen
    import histogram_pkg::*;
#(
    parameter int SAMPLE_BITS = 8
) (
    input  logic                   clk,
    input  logic                   arst_n,
    // generator mode, codes 6 and 7 hold
    input  gen_mode_t              mode,
    // range operands
    input  logic [SAMPLE_BITS-1:0] lo,
    input  logic [SAMPLE_BITS-1:0] hi,
    // generated stream
    output logic [SAMPLE_BITS-1:0] sample
);

    ////////////////////////////////////////
    // state
    ////////////////////////////////////////

    // current sample value
    logic [SAMPLE_BITS-1:0] sample_q;
    // registered copies of the operands
    logic [SAMPLE_BITS-1:0] lo_q;
    logic [SAMPLE_BITS-1:0] hi_q;
    // sample + 1, wraps at the sample width
    logic [SAMPLE_BITS-1:0] next_val;
    // hi + 1 for the exclusive jump, wraps too
    logic [SAMPLE_BITS-1:0] hi_plus;

    assign next_val = sample_q + 1'b1;
    assign hi_plus  = hi_q + 1'b1;

    ////////////////////////////////////////
    // operand registers
    ////////////////////////////////////////

    // lo and hi land here first, so they act two edges after being driven
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lo_q <= '0;
            hi_q <= '0;
        end else begin
            lo_q <= lo;
            hi_q <= hi;
        end
    end

    ////////////////////////////////////////
    // pattern state machine
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sample_q <= '0;
        end else begin
            case (mode)
                // synchronous clear, separate from arst_n
                MODE_RESET: sample_q <= '0;
                MODE_UNIFORM: sample_q <= next_val;
                MODE_CONSTANT: sample_q <= lo_q;
                MODE_INCL: begin
                    // stay inside [lo, hi], restart at lo
                    if ((next_val >= lo_q) && (next_val <= hi_q)) begin
                        sample_q <= next_val;
                    end else begin
                        sample_q <= lo_q;
                    end
                end
                MODE_EXCL: begin
                    // skip over [lo, hi] in one step
                    if ((next_val < lo_q) || (next_val > hi_q)) begin
                        sample_q <= next_val;
                    end else begin
                        sample_q <= hi_plus;
                    end
                end
                MODE_ALT: begin
                    if (sample_q == lo_q) begin
                        sample_q <= hi_q;
                    end else begin
                        sample_q <= lo_q;
                    end
                end
                // codes 6 and 7, stream frozen
                default: sample_q <= sample_q;
            endcase
        end
    end

    ////////////////////////////////////////
    // outputs
    ////////////////////////////////////////

    assign sample = sample_q;

endmodule

//--- source/histogram_bins.sv
module histogram_bins #(
    parameter int SAMPLE_BITS = 8,
    parameter int BIN_BITS    = 3,
    parameter int COUNT_BITS  = 16
) (
    input  logic                                   clk,
    input  logic                                   arst_n,
    // observed stream
    input  logic [SAMPLE_BITS-1:0]                 sample,
    // count enable, already aligned to sample
    input  logic                                   collect,
    // one cycle pulse, empties every bin
    input  logic                                   clear,
    // all counters side by side, bin 0 in the low bits
    output logic [(2**BIN_BITS)*COUNT_BITS-1:0]    bin_counts
);

    localparam int NUM_BINS = 2 ** BIN_BITS;

    ////////////////////////////////////////
    // bin decode
    ////////////////////////////////////////

    // bin index is the top BIN_BITS of the sample
    logic [BIN_BITS-1:0] bin_idx;

    assign bin_idx = sample[SAMPLE_BITS-1 -: BIN_BITS];

    ////////////////////////////////////////
    // counter bank
    ////////////////////////////////////////

    genvar i;
    generate
        for (i = 0; i < NUM_BINS; i++) begin : g_bin
            // one saturating counter per bin
            logic [COUNT_BITS-1:0] cnt_q;
            // this bin sees the current sample
            logic                  hit;
            // counter already at its top value
            logic                  full;

            assign hit  = collect && (bin_idx == BIN_BITS'(i));
            assign full = &cnt_q;

            always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                    cnt_q <= '0;
                end else if (clear) begin
                    // clear wins over a hit in the same cycle
                    cnt_q <= '0;
                end else if (hit && !full) begin
                    cnt_q <= cnt_q + 1'b1;
                end
            end

            // pack into the flat output
            assign bin_counts[i*COUNT_BITS +: COUNT_BITS] = cnt_q;
        end
    endgenerate

endmodule

//--- source/sample_stats.sv
module sample_stats #(
    parameter int SAMPLE_BITS = 8,
    parameter int COUNT_BITS  = 16
) (
    input  logic                   clk,
    input  logic                   arst_n,
    // observed stream
    input  logic [SAMPLE_BITS-1:0] sample,
    // count enable, aligned to sample
    input  logic                   collect,
    // one cycle pulse, restarts the statistics
    input  logic                   clear,
    output logic [SAMPLE_BITS-1:0] min_val,
    output logic [SAMPLE_BITS-1:0] max_val,
    output logic [COUNT_BITS-1:0]  sample_count
);

    ////////////////////////////////////////
    // running extremes
    ////////////////////////////////////////

    // min starts at all ones so the first sample always replaces it
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            min_val <= '1;
            max_val <= '0;
        end else if (clear) begin
            min_val <= '1;
            max_val <= '0;
        end else if (collect) begin
            if (sample < min_val) begin
                min_val <= sample;
            end
            if (sample > max_val) begin
                max_val <= sample;
            end
        end
    end

    ////////////////////////////////////////
    // sample counter
    ////////////////////////////////////////

    // saturates at all ones
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sample_count <= '0;
        end else if (clear) begin
            sample_count <= '0;
        end else if (collect && !(&sample_count)) begin
            sample_count <= sample_count + 1'b1;
        end
    end

endmodule

//--- source/histogram_readout.sv
module histogram_readout
    import histogram_pkg::*;
#(
    parameter int SAMPLE_BITS = 8,
    parameter int BIN_BITS    = 3,
    parameter int COUNT_BITS  = 16
) (
    input  logic                                clk,
    input  logic                                arst_n,
    // what to read
    input  rd_sel_t                             rd_sel,
    // bin number, only used with RD_BIN
    input  logic [BIN_BITS-1:0]                 rd_addr,
    // flat bin counters
    input  logic [(2**BIN_BITS)*COUNT_BITS-1:0] bin_counts,
    input  logic [SAMPLE_BITS-1:0]              min_val,
    input  logic [SAMPLE_BITS-1:0]              max_val,
    input  logic [COUNT_BITS-1:0]               sample_count,
    // registered read data
    output logic [COUNT_BITS-1:0]               rd_data
);

    // wide enough for either a sample or a counter
    localparam int EXT_BITS = (COUNT_BITS > SAMPLE_BITS) ? COUNT_BITS : SAMPLE_BITS;

    ////////////////////////////////////////
    // operand shaping
    ////////////////////////////////////////

    logic [EXT_BITS-1:0]   min_wide;
    logic [EXT_BITS-1:0]   max_wide;
    logic [COUNT_BITS-1:0] bin_sel;

    // zero extend, upper sample bits drop if counters are narrower
    assign min_wide = EXT_BITS'(min_val);
    assign max_wide = EXT_BITS'(max_val);
    assign bin_sel  = bin_counts[rd_addr*COUNT_BITS +: COUNT_BITS];

    // one cycle read latency
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_data <= '0;
        end else begin
            case (rd_sel)
                RD_BIN:   rd_data <= bin_sel;
                RD_MIN:   rd_data <= min_wide[COUNT_BITS-1:0];
                RD_MAX:   rd_data <= max_wide[COUNT_BITS-1:0];
                default:  rd_data <= sample_count;
            endcase
        end
    end

endmodule

//--- source/histogram_subsystem.sv
module histogram_subsystem
    import histogram_pkg::*;
#(
    parameter int SAMPLE_BITS = 8,
    parameter int BIN_BITS    = 3,
    parameter int COUNT_BITS  = 16
) (
    input  logic                   clk,
    input  logic                   arst_n,
    // generator control
    input  gen_mode_t              mode,
    input  logic [SAMPLE_BITS-1:0] lo,
    input  logic [SAMPLE_BITS-1:0] hi,
    // observer control
    input  logic                   collect,
    input  logic                   clear,
    // read port
    input  rd_sel_t                rd_sel,
    input  logic [BIN_BITS-1:0]    rd_addr,
    output logic [SAMPLE_BITS-1:0] sample,
    output logic [COUNT_BITS-1:0]  rd_data
);

    ////////////////////////////////////////
    // internal wiring
    ////////////////////////////////////////

    logic                                collect_q;
    logic [(2**BIN_BITS)*COUNT_BITS-1:0] bin_counts;
    logic [SAMPLE_BITS-1:0]              min_val;
    logic [SAMPLE_BITS-1:0]              max_val;
    logic [COUNT_BITS-1:0]               sample_count;

    // collect delayed one edge to line up with the sample it refers to
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            collect_q <= 1'b0;
        end else begin
            collect_q <= collect;
        end
    end

    ////////////////////////////////////////
    // blocks
    ////////////////////////////////////////

    histogram_data_gen #(.SAMPLE_BITS(SAMPLE_BITS)) u_data_gen (
        .clk(clk), .arst_n(arst_n), .mode(mode), .lo(lo), .hi(hi), .sample(sample)
    );

    // both observers watch the same stream
    histogram_bins #(
        .SAMPLE_BITS(SAMPLE_BITS), .BIN_BITS(BIN_BITS), .COUNT_BITS(COUNT_BITS)
    ) u_bins (
        .clk(clk), .arst_n(arst_n), .sample(sample), .collect(collect_q),
        .clear(clear), .bin_counts(bin_counts)
    );

    sample_stats #(.SAMPLE_BITS(SAMPLE_BITS), .COUNT_BITS(COUNT_BITS)) u_stats (
        .clk(clk), .arst_n(arst_n), .sample(sample), .collect(collect_q),
        .clear(clear), .min_val(min_val), .max_val(max_val), .sample_count(sample_count)
    );

    histogram_readout #(
        .SAMPLE_BITS(SAMPLE_BITS), .BIN_BITS(BIN_BITS), .COUNT_BITS(COUNT_BITS)
    ) u_readout (
        .clk(clk), .arst_n(arst_n), .rd_sel(rd_sel), .rd_addr(rd_addr),
        .bin_counts(bin_counts), .min_val(min_val), .max_val(max_val),
        .sample_count(sample_count), .rd_data(rd_data)
    );

endmodule

//--- verification/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk,
    output logic arst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset held low over the first three rising edges
    initial begin
        arst_n = 1'b0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

//--- verification/tb_histogram_subsystem.sv
module tb_histogram_subsystem
    import histogram_pkg::*;
#(
    parameter int COUNT_BITS = 16
) ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int SAMPLE_BITS     = 8;
    localparam int BIN_BITS        = 3;
    localparam int NUM_BINS        = 2 ** BIN_BITS;
    localparam int NUM_PHASES      = 12;
    localparam int RESET_TIMEOUT   = 20;
    localparam int WATCHDOG_CYCLES = 20000;

    // one row of the stimulus table
    typedef struct packed {
        logic [2:0]             mode_code;
        logic [SAMPLE_BITS-1:0] lo;
        logic [SAMPLE_BITS-1:0] hi;
        logic [15:0]            cycles;
        logic                   clear_first;
        logic                   rand_range;
    } phase_t;

    logic                   clk;
    logic                   arst_n;
    gen_mode_t              mode;
    logic [SAMPLE_BITS-1:0] lo;
    logic [SAMPLE_BITS-1:0] hi;
    logic                   collect;
    logic                   clear;
    rd_sel_t                rd_sel;
    logic [BIN_BITS-1:0]    rd_addr;
    logic [SAMPLE_BITS-1:0] sample;
    logic [COUNT_BITS-1:0]  rd_data;

    phase_t                 phases [NUM_PHASES];
    logic [31:0]            rng_state = 32'd19;
    int                     check_count = 0;
    int                     error_count = 0;
    logic [COUNT_BITS-1:0]  last_min;
    logic [COUNT_BITS-1:0]  last_max;

    tb_clock_gen u_clock_gen (.clk(clk), .arst_n(arst_n));

    histogram_subsystem #(
        .SAMPLE_BITS(SAMPLE_BITS), .BIN_BITS(BIN_BITS), .COUNT_BITS(COUNT_BITS)
    ) u_histogram_subsystem (
        .clk(clk), .arst_n(arst_n), .mode(mode), .lo(lo), .hi(hi),
        .collect(collect), .clear(clear), .rd_sel(rd_sel), .rd_addr(rd_addr),
        .sample(sample), .rd_data(rd_data)
    );

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    logic [SAMPLE_BITS-1:0] m_sample;
    logic [SAMPLE_BITS-1:0] m_lo_q;
    logic [SAMPLE_BITS-1:0] m_hi_q;
    logic [SAMPLE_BITS-1:0] m_min;
    logic [SAMPLE_BITS-1:0] m_max;
    logic                   m_collect_q;
    logic [COUNT_BITS-1:0]  m_count;
    logic [COUNT_BITS-1:0]  m_bins [NUM_BINS];
    logic [BIN_BITS-1:0]    m_idx;

    // bin is the top bits of the sample
    assign m_idx = m_sample[SAMPLE_BITS-1 -: BIN_BITS];

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // one generator step from the mode rules
    function automatic logic [SAMPLE_BITS-1:0] step_generator(
        input logic [2:0] code, input logic [SAMPLE_BITS-1:0] cur,
        input logic [SAMPLE_BITS-1:0] lo_r, input logic [SAMPLE_BITS-1:0] hi_r
    );
        logic [SAMPLE_BITS-1:0] nxt;
        nxt = cur + 1'b1;
        case (code)
            MODE_RESET:    step_generator = '0;
            MODE_UNIFORM:  step_generator = nxt;
            MODE_CONSTANT: step_generator = lo_r;
            MODE_INCL:     step_generator = (nxt >= lo_r && nxt <= hi_r) ? nxt : lo_r;
            MODE_EXCL:     step_generator = (nxt < lo_r || nxt > hi_r) ? nxt : hi_r + 1'b1;
            MODE_ALT:      step_generator = (cur == lo_r) ? hi_r : lo_r;
            // codes 6 and 7 keep cur
            default:       step_generator = cur;
        endcase
    endfunction

    // advances on the same edges as the DUT
    // inputs read before the tb update lands
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            m_sample    <= '0;
            m_lo_q      <= '0;
            m_hi_q      <= '0;
            m_collect_q <= 1'b0;
            m_min       <= '1;
            m_max       <= '0;
            m_count     <= '0;
            for (int b = 0; b < NUM_BINS; b++) begin
                m_bins[b] <= '0;
            end
        end else begin
            m_lo_q      <= lo;
            m_hi_q      <= hi;
            m_collect_q <= collect;
            m_sample    <= step_generator(mode, m_sample, m_lo_q, m_hi_q);
            if (clear) begin
                m_min   <= '1;
                m_max   <= '0;
                m_count <= '0;
                for (int b = 0; b < NUM_BINS; b++) begin
                    m_bins[b] <= '0;
                end
            end else if (m_collect_q) begin
                // saturating counters
                if (m_bins[m_idx] != '1) begin
                    m_bins[m_idx] <= m_bins[m_idx] + 1'b1;
                end
                if (m_count != '1) begin
                    m_count <= m_count + 1'b1;
                end
                if (m_sample < m_min) begin
                    m_min <= m_sample;
                end
                if (m_sample > m_max) begin
                    m_max <= m_sample;
                end
            end
        end
    end

    // stream compared at every falling edge
    always @(negedge clk) begin
        if (arst_n) begin
            check_count++;
            assert (sample == m_sample) else begin
                $display("Mismatch sample: got 0x%h, expected 0x%h", sample, m_sample);
                error_count++;
            end
        end
    end

    ////////////////////////////////////////
    // stimulus and readback
    ////////////////////////////////////////

    task automatic wait_cycles(input int n);
        for (int c = 0; c < n; c++) begin
            @(posedge clk);
        end
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (arst_n !== 1'b1 && n < RESET_TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (arst_n !== 1'b1) begin
            $display("reset was never released");
            error_count++;
        end
    endtask

    // ordered pair with lo never above hi
    task automatic draw_range(output logic [SAMPLE_BITS-1:0] a, output logic [SAMPLE_BITS-1:0] b);
        logic [SAMPLE_BITS-1:0] x;
        logic [SAMPLE_BITS-1:0] y;
        rng_state = xorshift32(rng_state);
        x = rng_state[SAMPLE_BITS-1:0];
        rng_state = xorshift32(rng_state);
        y = rng_state[SAMPLE_BITS-1:0];
        a = (x <= y) ? x : y;
        b = (x <= y) ? y : x;
    endtask

    // one registered read with the result valid after the next edge
    task automatic check_read(input rd_sel_t sel, input logic [BIN_BITS-1:0] addr,
                              input logic [COUNT_BITS-1:0] expected, input string name,
                              output logic [COUNT_BITS-1:0] got);
        @(posedge clk);
        rd_sel  <= sel;
        rd_addr <= addr;
        wait_cycles(1);
        @(negedge clk);
        got = rd_data;
        check_count++;
        assert (got == expected) else begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, expected);
            error_count++;
        end
    endtask

    task automatic read_all();
        logic [COUNT_BITS-1:0] got;
        for (int b = 0; b < NUM_BINS; b++) begin
            check_read(RD_BIN, BIN_BITS'(b), m_bins[b], $sformatf("bin[%0d]", b), got);
        end
        check_read(RD_MIN, '0, COUNT_BITS'(m_min), "min_val", last_min);
        check_read(RD_MAX, '0, COUNT_BITS'(m_max), "max_val", last_max);
        check_read(RD_COUNT, '0, m_count, "sample_count", got);
    endtask

    task automatic run_phase(input phase_t ph);
        logic [SAMPLE_BITS-1:0] lo_v;
        logic [SAMPLE_BITS-1:0] hi_v;
        int                     n;
        lo_v = ph.lo;
        hi_v = ph.hi;
        n    = int'(ph.cycles);
        if (ph.rand_range) begin
            draw_range(lo_v, hi_v);
        end
        @(posedge clk);
        mode  <= gen_mode_t'(ph.mode_code);
        lo    <= lo_v;
        hi    <= hi_v;
        clear <= ph.clear_first;
        @(posedge clk);
        clear <= 1'b0;
        // operands and mode settled by the next edge
        @(posedge clk);
        if (n != 0) begin
            collect <= 1'b1;
            wait_cycles(n);
            collect <= 1'b0;
        end
        // drain the collect pipeline
        wait_cycles(3);
        read_all();
        // inclusive range bounds when min and max fit the read port
        if (ph.mode_code == MODE_INCL && n != 0 && COUNT_BITS >= SAMPLE_BITS) begin
            check_count++;
            assert (last_min >= COUNT_BITS'(lo_v) && last_max <= COUNT_BITS'(hi_v)) else begin
                $display("Mismatch min_val, max_val: got 0x%h, 0x%h, expected within 0x%h to 0x%h",
                         last_min, last_max, lo_v, hi_v);
                error_count++;
            end
        end
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        mode    = MODE_RESET;
        lo      = '0;
        hi      = '0;
        collect = 1'b0;
        clear   = 1'b0;
        rd_sel  = RD_BIN;
        rd_addr = '0;
        // mode, lo, hi, collect cycles, clear first, random range
        phases[0]  = '{3'd0, 8'h00, 8'h00, 16'd0,   1'b0, 1'b0};
        phases[1]  = '{3'd1, 8'h00, 8'h00, 16'd256, 1'b1, 1'b0};
        phases[2]  = '{3'd2, 8'h5a, 8'hc3, 16'd40,  1'b1, 1'b0};
        phases[3]  = '{3'd5, 8'h23, 8'he7, 16'd50,  1'b1, 1'b0};
        phases[4]  = '{3'd3, 8'h00, 8'h00, 16'd60,  1'b1, 1'b1};
        phases[5]  = '{3'd4, 8'h00, 8'h00, 16'd60,  1'b1, 1'b1};
        phases[6]  = '{3'd3, 8'h00, 8'h00, 16'd90,  1'b1, 1'b1};
        phases[7]  = '{3'd4, 8'h00, 8'h00, 16'd45,  1'b1, 1'b1};
        phases[8]  = '{3'd6, 8'h11, 8'h22, 16'd30,  1'b1, 1'b0};
        phases[9]  = '{3'd7, 8'h33, 8'h44, 16'd20,  1'b0, 1'b0};
        phases[10] = '{3'd7, 8'h00, 8'h00, 16'd0,   1'b1, 1'b0};
        // long enough to saturate 4 bit counters
        phases[11] = '{3'd2, 8'h9e, 8'h00, 16'd20,  1'b1, 1'b0};
        wait_reset_release();
        if (error_count == 0) begin
            for (int p = 0; p < NUM_PHASES; p++) begin
                run_phase(phases[p]);
            end
        end
        $display("checks: %0d  errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // upper bound on run length
    initial begin
        wait_cycles(WATCHDOG_CYCLES);
        $display("simulation ran past its cycle budget");
        $display("Test failed");
        $finish;
    end

endmodule

//--- histogram_subsystem.f
source/histogram_pkg.sv
source/histogram_data_gen.sv
source/histogram_bins.sv
source/sample_stats.sv
source/histogram_readout.sv
source/histogram_subsystem.sv
verification/tb_clock_gen.sv
verification/tb_histogram_subsystem.sv

//--- run_verilator.sh
#!/bin/sh
# second build narrows the counters so saturation is exercised
PASS_TEXT="Test completed successfully"
VFLAGS="--binary --assert --timescale 1ns/1ps --top-module tb_histogram_subsystem"
verilator $VFLAGS -f histogram_subsystem.f -Mdir obj_dir_wide \
    && verilator $VFLAGS -GCOUNT_BITS=4 -f histogram_subsystem.f -Mdir obj_dir_narrow \
    && ./obj_dir_wide/Vtb_histogram_subsystem | tee /dev/stderr | grep -q "$PASS_TEXT" \
    && ./obj_dir_narrow/Vtb_histogram_subsystem | tee /dev/stderr | grep -q "$PASS_TEXT" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
